/* design/csr_pkg.sv */
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int CSR_NUM    = 19;
    localparam int CSR_IDX_W  = $clog2(CSR_NUM);
    localparam int CSROP_W    = 3;
    localparam int EXC_W      = 5;
    localparam int ASID_W     = 9;  // Sv32 satp fields.
    localparam int PPN_W      = 22;

    localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID  = 12'hF14;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SSTATUS  = 12'h100;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] ADDR_STVEC    = 12'h105;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEDELEG  = 12'h302;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SIE      = 12'h104;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP      = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SIP      = 12'h144;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SSCRATCH = 12'h140;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SEPC     = 12'h141;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SCAUSE   = 12'h142;
    localparam logic [CSR_ADDR_W-1:0] ADDR_SATP     = 12'h180;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE   = 12'hB00;

    localparam logic [CSR_IDX_W-1:0] IDX_MHARTID  = 5'd0;
    localparam logic [CSR_IDX_W-1:0] IDX_MISA     = 5'd1;
    localparam logic [CSR_IDX_W-1:0] IDX_MSTATUS  = 5'd2;
    localparam logic [CSR_IDX_W-1:0] IDX_SSTATUS  = 5'd3;
    localparam logic [CSR_IDX_W-1:0] IDX_MTVEC    = 5'd4;
    localparam logic [CSR_IDX_W-1:0] IDX_STVEC    = 5'd5;
    localparam logic [CSR_IDX_W-1:0] IDX_MEDELEG  = 5'd6;
    localparam logic [CSR_IDX_W-1:0] IDX_MIE      = 5'd7;
    localparam logic [CSR_IDX_W-1:0] IDX_SIE      = 5'd8;
    localparam logic [CSR_IDX_W-1:0] IDX_MIP      = 5'd9;
    localparam logic [CSR_IDX_W-1:0] IDX_SIP      = 5'd10;
    localparam logic [CSR_IDX_W-1:0] IDX_MSCRATCH = 5'd11;
    localparam logic [CSR_IDX_W-1:0] IDX_SSCRATCH = 5'd12;
    localparam logic [CSR_IDX_W-1:0] IDX_MEPC     = 5'd13;
    localparam logic [CSR_IDX_W-1:0] IDX_SEPC     = 5'd14;
    localparam logic [CSR_IDX_W-1:0] IDX_MCAUSE   = 5'd15;
    localparam logic [CSR_IDX_W-1:0] IDX_SCAUSE   = 5'd16;
    localparam logic [CSR_IDX_W-1:0] IDX_SATP     = 5'd17;
    localparam logic [CSR_IDX_W-1:0] IDX_MCYCLE   = 5'd18;

    // Bit 2 selects the immediate source.
    localparam logic [CSROP_W-1:0] OP_RW = 3'b001;
    localparam logic [CSROP_W-1:0] OP_RS = 3'b010;
    localparam logic [CSROP_W-1:0] OP_RC = 3'b011;

    localparam logic [EXC_W-1:0] EXC_II    = 5'd2;
    localparam logic [EXC_W-1:0] EXC_BREAK = 5'd3;
    localparam logic [EXC_W-1:0] EXC_ECALL = 5'd8;  // Plus current mode.
    localparam logic [EXC_W-1:0] EXC_MRET  = 5'd24;
    localparam logic [EXC_W-1:0] EXC_SRET  = 5'd25;
    localparam logic [EXC_W-1:0] EXC_NONE  = 5'd31;

    localparam logic [1:0] PRIV_U = 2'd0;
    localparam logic [1:0] PRIV_S = 2'd1;
    localparam logic [1:0] PRIV_M = 2'd3;

    localparam logic [XLEN-1:0] STATUS_MASK  = 32'h005E_19AA;
    localparam logic [XLEN-1:0] SSTATUS_MASK = 32'h000C_0122;
    localparam logic [XLEN-1:0] SIP_MASK     = 32'h0000_0222;
    localparam logic [XLEN-1:0] TVEC_MASK    = 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] MEDELEG_MASK = 32'h0000_F7FF;  // No ecall from M.
    localparam logic [XLEN-1:0] MISA_INIT    = 32'h4014_1100;  // RV32 IMSU.
    localparam logic [XLEN-1:0] MHARTID_VAL  = 32'h0000_0000;

    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [8:0] rsv_hi;
            logic       tsr;
            logic       rsv_tw;
            logic       tvm;
            logic       mxr;
            logic       sum;
            logic       mprv;
            logic [3:0] rsv_fs;
            logic [1:0] mpp;
            logic [1:0] rsv_vs;
            logic       spp;
            logic       mpie;
            logic       rsv_ube;
            logic       spie;
            logic       rsv_4;
            logic       mie;
            logic       rsv_2;
            logic       sie;
            logic       rsv_0;
        } f;
    } csr_status_u;

endpackage

/* design/csr_access.sv */
module csr_access import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  csr_en,
    input  logic [CSROP_W-1:0]    csr_op,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic [XLEN-1:0]       csr_src,
    input  logic [4:0]            csr_imm,
    input  logic                  trap_en,
    input  logic [1:0]            priv_mode,
    input  logic                  status_tvm,
    input  logic [XLEN-1:0]       rd_data,
    output logic [CSR_IDX_W-1:0]  rd_idx,
    output logic                  wr_en,
    output logic [CSR_IDX_W-1:0]  wr_idx,
    output logic [XLEN-1:0]       wr_data,
    output logic                  wb_valid,
    output logic [XLEN-1:0]       wb_data,
    output logic [EXC_W-1:0]      wb_exc
);

    logic            known;
    logic [XLEN-1:0] src;
    logic            is_rw;
    logic            is_rs;
    logic            is_rc;
    logic            writes;
    logic            illegal;

    always_comb begin
        known  = 1'b1;
        rd_idx = '0;
        case (csr_addr)
            ADDR_MHARTID:  rd_idx = IDX_MHARTID;
            ADDR_MISA:     rd_idx = IDX_MISA;
            ADDR_MSTATUS:  rd_idx = IDX_MSTATUS;
            ADDR_SSTATUS:  rd_idx = IDX_SSTATUS;
            ADDR_MTVEC:    rd_idx = IDX_MTVEC;
            ADDR_STVEC:    rd_idx = IDX_STVEC;
            ADDR_MEDELEG:  rd_idx = IDX_MEDELEG;
            ADDR_MIE:      rd_idx = IDX_MIE;
            ADDR_SIE:      rd_idx = IDX_SIE;
            ADDR_MIP:      rd_idx = IDX_MIP;
            ADDR_SIP:      rd_idx = IDX_SIP;
            ADDR_MSCRATCH: rd_idx = IDX_MSCRATCH;
            ADDR_SSCRATCH: rd_idx = IDX_SSCRATCH;
            ADDR_MEPC:     rd_idx = IDX_MEPC;
            ADDR_SEPC:     rd_idx = IDX_SEPC;
            ADDR_MCAUSE:   rd_idx = IDX_MCAUSE;
            ADDR_SCAUSE:   rd_idx = IDX_SCAUSE;
            ADDR_SATP:     rd_idx = IDX_SATP;
            ADDR_MCYCLE:   rd_idx = IDX_MCYCLE;
            default:       known = 1'b0;
        endcase
    end

    assign src   = csr_op[2] ? {{(XLEN-5){1'b0}}, csr_imm} : csr_src;
    assign is_rw = csr_op[1:0] == OP_RW[1:0];
    assign is_rs = csr_op[1:0] == OP_RS[1:0];
    assign is_rc = csr_op[1:0] == OP_RC[1:0];
    // Set and clear with a zero source are pure reads.
    assign writes = is_rw | ((is_rs | is_rc) & (src != '0));

    assign illegal = !known
                   || (csr_addr[9:8] > priv_mode)
                   || (writes && csr_addr[11:10] == 2'b11)
                   || (priv_mode == PRIV_S && rd_idx == IDX_SATP && status_tvm);

    assign wr_en   = csr_en & writes & ~illegal & ~trap_en;
    assign wr_idx  = rd_idx;
    assign wr_data = is_rw ? src : is_rs ? (rd_data | src) : (rd_data & ~src);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= csr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_en) begin
            wb_data <= illegal ? '0 : rd_data;
            wb_exc  <= illegal ? EXC_II : EXC_NONE;
        end
    end

    // Unknown addresses decode to slot 0, the read-only mhartid.
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> wr_idx != IDX_MHARTID);

endmodule

/* design/csr_regfile.sv */
module csr_regfile import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [CSR_IDX_W-1:0] rd_idx,
    input  logic                 wr_en,
    input  logic [CSR_IDX_W-1:0] wr_idx,
    input  logic [XLEN-1:0]      wr_data,
    input  logic [1:0]           priv_mode,
    input  logic                 trap_take,
    input  logic                 trap_to_s,
    input  logic [EXC_W-1:0]     trap_cause,
    input  logic [XLEN-1:0]      trap_pc,
    input  logic                 mret_take,
    input  logic                 sret_take,
    output logic [XLEN-1:0]      rd_data,
    output csr_status_u          status,
    output logic [XLEN-1:0]      medeleg,
    output logic [XLEN-1:0]      mtvec,
    output logic [XLEN-1:0]      stvec,
    output logic [XLEN-1:0]      mepc,
    output logic [XLEN-1:0]      sepc,
    output logic [1:0]           xlat_mode,
    output logic                 xlat_sum,
    output logic                 xlat_mxr,
    output logic [ASID_W-1:0]    xlat_asid,
    output logic [PPN_W-1:0]     xlat_ppn
);

    csr_status_u     status_nxt;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] sscratch;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] scause;
    logic [XLEN-1:0] satp;
    logic [XLEN-1:0] mcycle;

    function automatic logic [XLEN-1:0] merge(input logic [XLEN-1:0] old_val,
                                              input logic [XLEN-1:0] new_val,
                                              input logic [XLEN-1:0] mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    always_comb begin
        case (rd_idx)
            IDX_MHARTID:  rd_data = MHARTID_VAL;
            IDX_MISA:     rd_data = MISA_INIT;
            IDX_MSTATUS:  rd_data = status.raw;
            IDX_SSTATUS:  rd_data = status.raw & SSTATUS_MASK;
            IDX_MTVEC:    rd_data = mtvec;
            IDX_STVEC:    rd_data = stvec;
            IDX_MEDELEG:  rd_data = medeleg;
            IDX_MIE:      rd_data = mie;
            IDX_SIE:      rd_data = mie & SIP_MASK;
            IDX_MIP:      rd_data = mip;
            IDX_SIP:      rd_data = mip & SIP_MASK;
            IDX_MSCRATCH: rd_data = mscratch;
            IDX_SSCRATCH: rd_data = sscratch;
            IDX_MEPC:     rd_data = mepc;
            IDX_SEPC:     rd_data = sepc;
            IDX_MCAUSE:   rd_data = mcause;
            IDX_SCAUSE:   rd_data = scause;
            IDX_SATP:     rd_data = satp;
            IDX_MCYCLE:   rd_data = mcycle;
            default:      rd_data = '0;
        endcase
    end

    // Software write first, trap and return stacking override it.
    always_comb begin
        status_nxt = status;
        if (wr_en && wr_idx == IDX_MSTATUS) begin
            status_nxt.raw = wr_data & STATUS_MASK;
            if (status_nxt.f.mpp == 2'b10)
                status_nxt.f.mpp = status.f.mpp;  // Reserved mode, keep old.
        end else if (wr_en && wr_idx == IDX_SSTATUS) begin
            status_nxt.raw = merge(status.raw, wr_data, SSTATUS_MASK);
        end
        if (trap_take && trap_to_s) begin
            status_nxt.f.spp  = priv_mode[0];
            status_nxt.f.spie = status.f.sie;
            status_nxt.f.sie  = 1'b0;
        end else if (trap_take) begin
            status_nxt.f.mpp  = priv_mode;
            status_nxt.f.mpie = status.f.mie;
            status_nxt.f.mie  = 1'b0;
        end else if (mret_take) begin
            status_nxt.f.mie  = status.f.mpie;
            status_nxt.f.mpie = 1'b1;
        end else if (sret_take) begin
            status_nxt.f.sie  = status.f.spie;
            status_nxt.f.spie = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status   <= '0;
            mtvec    <= '0;
            stvec    <= '0;
            medeleg  <= '0;
            mie      <= '0;
            mip      <= '0;
            mscratch <= '0;
            sscratch <= '0;
            mepc     <= '0;
            sepc     <= '0;
            mcause   <= '0;
            scause   <= '0;
            satp     <= '0;
            mcycle   <= '0;
        end else begin
            status <= status_nxt;
            mcycle <= (wr_en && wr_idx == IDX_MCYCLE) ? wr_data : mcycle + 32'd1;
            if (wr_en) begin
                case (wr_idx)
                    IDX_MTVEC:    mtvec    <= wr_data & TVEC_MASK;
                    IDX_STVEC:    stvec    <= wr_data & TVEC_MASK;
                    IDX_MEDELEG:  medeleg  <= wr_data & MEDELEG_MASK;
                    IDX_MIE:      mie      <= wr_data;
                    IDX_SIE:      mie      <= merge(mie, wr_data, SIP_MASK);
                    IDX_MIP:      mip      <= wr_data;
                    IDX_SIP:      mip      <= merge(mip, wr_data, SIP_MASK);
                    IDX_MSCRATCH: mscratch <= wr_data;
                    IDX_SSCRATCH: sscratch <= wr_data;
                    IDX_MEPC:     mepc     <= wr_data;
                    IDX_SEPC:     sepc     <= wr_data;
                    IDX_MCAUSE:   mcause   <= wr_data;
                    IDX_SCAUSE:   scause   <= wr_data;
                    IDX_SATP:     satp     <= wr_data;
                    default: ;
                endcase
            end
            if (trap_take && trap_to_s) begin
                sepc   <= trap_pc;
                scause <= {{(XLEN-EXC_W){1'b0}}, trap_cause};
            end else if (trap_take) begin
                mepc   <= trap_pc;
                mcause <= {{(XLEN-EXC_W){1'b0}}, trap_cause};
            end
        end
    end

    // Effective data-access mode honours mprv.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xlat_mode <= PRIV_M;
            xlat_sum  <= 1'b0;
            xlat_mxr  <= 1'b0;
            xlat_asid <= '0;
            xlat_ppn  <= '0;
        end else begin
            xlat_mode <= (priv_mode == PRIV_M && status.f.mprv) ? status.f.mpp : priv_mode;
            xlat_sum  <= status.f.sum;
            xlat_mxr  <= status.f.mxr;
            xlat_asid <= satp[PPN_W+ASID_W-1:PPN_W];
            xlat_ppn  <= satp[PPN_W-1:0];
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({trap_take, mret_take, sret_take}));

endmodule

/* design/trap_ctrl.sv */
module trap_ctrl import csr_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             trap_en,
    input  logic [EXC_W-1:0] trap_code,
    input  csr_status_u      status,
    input  logic [XLEN-1:0]  medeleg,
    input  logic [XLEN-1:0]  mtvec,
    input  logic [XLEN-1:0]  stvec,
    input  logic [XLEN-1:0]  mepc,
    input  logic [XLEN-1:0]  sepc,
    output logic [1:0]       priv_mode,
    output logic             trap_take,
    output logic             trap_to_s,
    output logic [EXC_W-1:0] trap_cause,
    output logic             mret_take,
    output logic             sret_take,
    output logic [XLEN-1:0]  target_pc
);

    logic is_mret;
    logic is_sret;
    logic mret_ok;
    logic sret_ok;
    logic ret_bad;

    assign is_mret = trap_code == EXC_MRET;
    assign is_sret = trap_code == EXC_SRET;
    assign mret_ok = priv_mode == PRIV_M;
    // tsr traps SRET executed in S mode.
    assign sret_ok = priv_mode == PRIV_M || (priv_mode == PRIV_S && !status.f.tsr);
    assign ret_bad = (is_mret && !mret_ok) || (is_sret && !sret_ok);

    always_comb begin
        if (trap_code == EXC_ECALL)
            trap_cause = EXC_ECALL + EXC_W'(priv_mode);
        else if (ret_bad)
            trap_cause = EXC_II;
        else
            trap_cause = trap_code;
    end

    assign mret_take = trap_en && is_mret && mret_ok;
    assign sret_take = trap_en && is_sret && sret_ok;
    assign trap_take = trap_en && !mret_take && !sret_take;
    assign trap_to_s = medeleg[trap_cause] && priv_mode != PRIV_M;

    always_comb begin
        if (is_mret && mret_ok)
            target_pc = mepc;
        else if (is_sret && sret_ok)
            target_pc = sepc;
        else if (trap_to_s)
            target_pc = stvec;
        else
            target_pc = mtvec;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            priv_mode <= PRIV_M;
        end else if (trap_take) begin
            priv_mode <= trap_to_s ? PRIV_S : PRIV_M;
        end else if (mret_take) begin
            priv_mode <= status.f.mpp;
        end else if (sret_take) begin
            priv_mode <= status.f.spp ? PRIV_S : PRIV_U;
        end
    end

    // Holds only while the register file keeps mpp legal.
    assert property (@(posedge clk) disable iff (rst) priv_mode != 2'b10);

endmodule

/* design/csr_unit.sv */
module csr_unit import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  csr_en,
    input  logic [CSROP_W-1:0]    csr_op,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    input  logic [XLEN-1:0]       csr_src,
    input  logic [4:0]            csr_imm,
    input  logic                  trap_en,
    input  logic [EXC_W-1:0]      trap_code,
    input  logic [XLEN-1:0]       trap_pc,
    output logic                  wb_valid,
    output logic [XLEN-1:0]       wb_data,
    output logic [EXC_W-1:0]      wb_exc,
    output logic [XLEN-1:0]       target_pc,
    output logic [1:0]            priv_mode,
    output logic [1:0]            xlat_mode,
    output logic                  xlat_sum,
    output logic                  xlat_mxr,
    output logic [ASID_W-1:0]     xlat_asid,
    output logic [PPN_W-1:0]      xlat_ppn
);

    logic [CSR_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      rd_data;
    logic                 wr_en;
    logic [CSR_IDX_W-1:0] wr_idx;
    logic [XLEN-1:0]      wr_data;
    csr_status_u          status;
    logic [XLEN-1:0]      medeleg;
    logic [XLEN-1:0]      mtvec;
    logic [XLEN-1:0]      stvec;
    logic [XLEN-1:0]      mepc;
    logic [XLEN-1:0]      sepc;
    logic                 trap_take;
    logic                 trap_to_s;
    logic [EXC_W-1:0]     trap_cause;
    logic                 mret_take;
    logic                 sret_take;

    csr_access u_access (
        .clk        (clk),
        .rst        (rst),
        .csr_en     (csr_en),
        .csr_op     (csr_op),
        .csr_addr   (csr_addr),
        .csr_src    (csr_src),
        .csr_imm    (csr_imm),
        .trap_en    (trap_en),
        .priv_mode  (priv_mode),
        .status_tvm (status.f.tvm),
        .rd_data    (rd_data),
        .rd_idx     (rd_idx),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .wb_exc     (wb_exc)
    );

    csr_regfile u_regs (
        .clk        (clk),
        .rst        (rst),
        .rd_idx     (rd_idx),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .priv_mode  (priv_mode),
        .trap_take  (trap_take),
        .trap_to_s  (trap_to_s),
        .trap_cause (trap_cause),
        .trap_pc    (trap_pc),
        .mret_take  (mret_take),
        .sret_take  (sret_take),
        .rd_data    (rd_data),
        .status     (status),
        .medeleg    (medeleg),
        .mtvec      (mtvec),
        .stvec      (stvec),
        .mepc       (mepc),
        .sepc       (sepc),
        .xlat_mode  (xlat_mode),
        .xlat_sum   (xlat_sum),
        .xlat_mxr   (xlat_mxr),
        .xlat_asid  (xlat_asid),
        .xlat_ppn   (xlat_ppn)
    );

    trap_ctrl u_trap (
        .clk        (clk),
        .rst        (rst),
        .trap_en    (trap_en),
        .trap_code  (trap_code),
        .status     (status),
        .medeleg    (medeleg),
        .mtvec      (mtvec),
        .stvec      (stvec),
        .mepc       (mepc),
        .sepc       (sepc),
        .priv_mode  (priv_mode),
        .trap_take  (trap_take),
        .trap_to_s  (trap_to_s),
        .trap_cause (trap_cause),
        .mret_take  (mret_take),
        .sret_take  (sret_take),
        .target_pc  (target_pc)
    );

endmodule

/* verification/csr_unit_tests.svh */
`ifndef CSR_UNIT_TESTS_SVH
`define CSR_UNIT_TESTS_SVH

// One row per test. CSR rows check wb_data, wb_exc and mode.
// Redirect rows check target_pc and the mode after the edge.
typedef struct {
    string                 name;
    bit                    redirect;
    logic [CSROP_W-1:0]    op;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       src;       // Redirect PC on redirect rows.
    logic [4:0]            imm;
    logic [EXC_W-1:0]      code;
    logic [XLEN-1:0]       exp_word;  // Old CSR value or target PC.
    logic [EXC_W-1:0]      exp_exc;
    logic [1:0]            exp_mode;
} test_t;

test_t tests[$];

function automatic void csr_row(input string name, input logic [CSROP_W-1:0] op,
                                input logic [CSR_ADDR_W-1:0] addr,
                                input logic [XLEN-1:0] src, input logic [4:0] imm,
                                input logic [XLEN-1:0] exp_data,
                                input logic [EXC_W-1:0] exp_exc);
    test_t t;
    t = '{name, 1'b0, op, addr, src, imm, EXC_NONE, exp_data, exp_exc, row_mode};
    tests.push_back(t);
endfunction

function automatic void redirect_row(input string name, input logic [EXC_W-1:0] code,
                                     input logic [XLEN-1:0] pc,
                                     input logic [XLEN-1:0] exp_target,
                                     input logic [1:0] exp_mode);
    test_t t;
    t = '{name, 1'b1, '0, '0, pc, 5'd0, code, exp_target, EXC_NONE, exp_mode};
    tests.push_back(t);
    row_mode = exp_mode;  // Later rows run in the new mode.
endfunction

// Expected values track the CSR state that each row leaves behind.
function automatic void build_table(input logic [XLEN-1:0] rnd);
    logic [XLEN-1:0] scratch;
    logic [XLEN-1:0] mstat;
    csr_row("mscratch_rw_reg", OP_RW, ADDR_MSCRATCH, rnd, 5'd0, 32'h0, EXC_NONE);
    csr_row("mscratch_rs_reg", OP_RS, ADDR_MSCRATCH, 32'hf0, 5'd0, rnd, EXC_NONE);
    scratch = rnd | 32'hf0;
    csr_row("mscratch_rc_reg", OP_RC, ADDR_MSCRATCH, 32'h0f, 5'd0, scratch, EXC_NONE);
    scratch = scratch & ~32'h0f;
    csr_row("mscratch_rsi_zero", OP_RSI, ADDR_MSCRATCH, '0, 5'd0, scratch, EXC_NONE);
    csr_row("mscratch_rci", OP_RCI, ADDR_MSCRATCH, '0, 5'h10, scratch, EXC_NONE);
    scratch = scratch & ~32'h10;
    csr_row("mscratch_rwi", OP_RWI, ADDR_MSCRATCH, '0, 5'h1f, scratch, EXC_NONE);
    scratch = 32'h1f;
    csr_row("mscratch_read", OP_RSI, ADDR_MSCRATCH, '0, 5'd0, scratch, EXC_NONE);
    mstat = SSTATUS_MASK;  // Only the view bits land in mstatus.
    csr_row("sstatus_all_ones", OP_RW, ADDR_SSTATUS, '1, 5'd0, 32'h0, EXC_NONE);
    csr_row("mstatus_view", OP_RSI, ADDR_MSTATUS, '0, 5'd0, mstat, EXC_NONE);
    csr_row("mtvec_write", OP_RW, ADDR_MTVEC, 32'h8000_0103, 5'd0, 32'h0, EXC_NONE);
    csr_row("mtvec_read", OP_RSI, ADDR_MTVEC, '0, 5'd0, 32'h8000_0100, EXC_NONE);
    csr_row("stvec_write", OP_RW, ADDR_STVEC, 32'h8000_0207, 5'd0, 32'h0, EXC_NONE);
    csr_row("unknown_addr", OP_RW, 12'h7c0, 32'h1, 5'd0, 32'h0, EXC_II);
    csr_row("mhartid_write", OP_RW, ADDR_MHARTID, 32'hffff, 5'd0, 32'h0, EXC_II);
    csr_row("mhartid_read", OP_RSI, ADDR_MHARTID, '0, 5'd0, 32'h0, EXC_NONE);
    csr_row("mstatus_set_mie", OP_RSI, ADDR_MSTATUS, '0, 5'h08, mstat, EXC_NONE);
    mstat = mstat | 32'h8;
    redirect_row("ecall_from_m", EXC_ECALL, 32'h1000, 32'h8000_0100, PRIV_M);
    mstat = (mstat | 32'h1880) & ~32'h8;  // mpp = M, mpie = old mie, mie clear.
    csr_row("mepc_after_ecall", OP_RSI, ADDR_MEPC, '0, 5'd0, 32'h1000, EXC_NONE);
    csr_row("mcause_after_ecall", OP_RSI, ADDR_MCAUSE, '0, 5'd0, 32'd11, EXC_NONE);
    csr_row("mstatus_after_ecall", OP_RSI, ADDR_MSTATUS, '0, 5'd0, mstat, EXC_NONE);
    csr_row("medeleg_ecall_u", OP_RW, ADDR_MEDELEG, 32'h100, 5'd0, 32'h0, EXC_NONE);
    csr_row("mstatus_clear_mpp", OP_RC, ADDR_MSTATUS, 32'h1800, 5'd0, mstat, EXC_NONE);
    mstat = mstat & ~32'h1800;
    csr_row("mstatus_set_tvm", OP_RS, ADDR_MSTATUS, 32'h0010_0000, 5'd0, mstat, EXC_NONE);
    mstat = mstat | 32'h0010_0000;
    redirect_row("mret_to_u", EXC_MRET, 32'h0, 32'h1000, PRIV_U);
    mstat = mstat | 32'h8;  // mie takes mpie.
    redirect_row("ecall_from_u", EXC_ECALL, 32'h2000, 32'h8000_0204, PRIV_S);
    mstat = mstat & ~32'h102;  // spp = U, spie = old sie, sie clear.
    csr_row("scause_deleg", OP_RSI, ADDR_SCAUSE, '0, 5'd0, 32'd8, EXC_NONE);
    csr_row("sepc_deleg", OP_RSI, ADDR_SEPC, '0, 5'd0, 32'h2000, EXC_NONE);
    redirect_row("sret_to_u", EXC_SRET, 32'h0, 32'h2000, PRIV_U);
    mstat = mstat | 32'h2;
    redirect_row("ecall_from_u_again", EXC_ECALL, 32'h3000, 32'h8000_0204, PRIV_S);
    mstat = mstat & ~32'h102;
    csr_row("s_mscratch", OP_RW, ADDR_MSCRATCH, 32'hdead, 5'd0, 32'h0, EXC_II);
    csr_row("s_satp_tvm", OP_RW, ADDR_SATP, 32'h8000_0001, 5'd0, 32'h0, EXC_II);
    redirect_row("mret_from_s", EXC_MRET, 32'h4000, 32'h8000_0100, PRIV_M);
    mstat = (mstat & ~32'h1808) | 32'h0880;  // mpp = S, mpie = old mie.
    csr_row("mcause_ii", OP_RSI, ADDR_MCAUSE, '0, 5'd0, XLEN'(EXC_II), EXC_NONE);
    csr_row("mepc_ii", OP_RSI, ADDR_MEPC, '0, 5'd0, 32'h4000, EXC_NONE);
    csr_row("mscratch_kept", OP_RSI, ADDR_MSCRATCH, '0, 5'd0, scratch, EXC_NONE);
    csr_row("satp_kept", OP_RSI, ADDR_SATP, '0, 5'd0, 32'h0, EXC_NONE);
    csr_row("satp_write", OP_RW, ADDR_SATP, {1'b1, SATP_ASID, SATP_PPN},
            5'd0, 32'h0, EXC_NONE);
    csr_row("mstatus_set_mprv", OP_RS, ADDR_MSTATUS, 32'h0002_0000, 5'd0, mstat, EXC_NONE);
endfunction

`endif

/* verification/csr_unit_tb.sv */
module csr_unit_tb import csr_pkg::*; ();

    localparam logic [CSROP_W-1:0] OP_RWI = OP_RW | 3'b100;
    localparam logic [CSROP_W-1:0] OP_RSI = OP_RS | 3'b100;
    localparam logic [CSROP_W-1:0] OP_RCI = OP_RC | 3'b100;

    localparam logic [ASID_W-1:0] SATP_ASID = 9'h0a5;
    localparam logic [PPN_W-1:0]  SATP_PPN  = 22'h0_1234;

    logic                  clk;
    logic                  rst;
    logic                  csr_en;
    logic [CSROP_W-1:0]    csr_op;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       csr_src;
    logic [4:0]            csr_imm;
    logic                  trap_en;
    logic [EXC_W-1:0]      trap_code;
    logic [XLEN-1:0]       trap_pc;
    logic                  wb_valid;
    logic [XLEN-1:0]       wb_data;
    logic [EXC_W-1:0]      wb_exc;
    logic [XLEN-1:0]       target_pc;
    logic [1:0]            priv_mode;
    logic [1:0]            xlat_mode;
    logic                  xlat_sum;
    logic                  xlat_mxr;
    logic [ASID_W-1:0]     xlat_asid;
    logic [PPN_W-1:0]      xlat_ppn;

    integer          seed;
    logic [XLEN-1:0] rand_val;
    logic [1:0]      row_mode;
    int              cycles = 0;
    int              cycle_limit = 0;
    int              errors = 0;
    int              n_pass = 0;
    int              n_fail = 0;

    `include "csr_unit_tests.svh"

    csr_unit u_dut (
        .clk       (clk),
        .rst       (rst),
        .csr_en    (csr_en),
        .csr_op    (csr_op),
        .csr_addr  (csr_addr),
        .csr_src   (csr_src),
        .csr_imm   (csr_imm),
        .trap_en   (trap_en),
        .trap_code (trap_code),
        .trap_pc   (trap_pc),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data),
        .wb_exc    (wb_exc),
        .target_pc (target_pc),
        .priv_mode (priv_mode),
        .xlat_mode (xlat_mode),
        .xlat_sum  (xlat_sum),
        .xlat_mxr  (xlat_mxr),
        .xlat_asid (xlat_asid),
        .xlat_ppn  (xlat_ppn)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the test loop did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input string what,
                              input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %h actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_exc(input string name, input logic [EXC_W-1:0] exp,
                             input logic [EXC_W-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s wb_exc expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_mode(input string name, input logic [1:0] exp,
                              input logic [1:0] act);
        if (act !== exp) begin
            $display("** Error: %s priv_mode expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_xlat(input string name, input logic [1:0] exp_mode,
                              input logic exp_sum, input logic exp_mxr,
                              input logic [ASID_W-1:0] exp_asid,
                              input logic [PPN_W-1:0] exp_ppn);
        if ({xlat_mode, xlat_sum, xlat_mxr, xlat_asid, xlat_ppn}
                !== {exp_mode, exp_sum, exp_mxr, exp_asid, exp_ppn}) begin
            $write("** Error: %s xlat expected mode %0d sum %b mxr %b asid %h ppn %h",
                   name, exp_mode, exp_sum, exp_mxr, exp_asid, exp_ppn);
            $display(" actual mode %0d sum %b mxr %b asid %h ppn %h",
                     xlat_mode, xlat_sum, xlat_mxr, xlat_asid, xlat_ppn);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            n_pass++;
            $display("PASS  %s", name);
        end else begin
            n_fail++;
            $display("FAIL  %s", name);
        end
    endtask

    // One cycle of stimulus, then the result one cycle later.
    task automatic apply_test(input test_t t);
        int errors_before;
        errors_before = errors;
        @(posedge clk);
        if (t.redirect) begin
            trap_en   <= 1'b1;
            trap_code <= t.code;
            trap_pc   <= t.src;
        end else begin
            csr_en   <= 1'b1;
            csr_op   <= t.op;
            csr_addr <= t.addr;
            csr_src  <= t.src;
            csr_imm  <= t.imm;
        end
        @(negedge clk);
        if (t.redirect)
            check_word(t.name, "target_pc", t.exp_word, target_pc);  // Same-cycle PC.
        @(posedge clk);
        csr_en  <= 1'b0;
        trap_en <= 1'b0;
        @(negedge clk);
        if (!t.redirect) begin
            if (wb_valid !== 1'b1) begin
                $display("Test %s: no writeback one cycle after csr_en", t.name);
                errors++;
            end
            if (t.exp_exc == EXC_NONE)
                check_word(t.name, "wb_data", t.exp_word, wb_data);
            check_exc(t.name, t.exp_exc, wb_exc);
        end
        check_mode(t.name, t.exp_mode, priv_mode);
        report_test(t.name, errors_before);
    endtask

    // Translation context sampled away from the clock edge.
    task automatic xlat_test(input string name, input logic [1:0] exp_mode,
                             input logic exp_sum, input logic exp_mxr,
                             input logic [ASID_W-1:0] exp_asid,
                             input logic [PPN_W-1:0] exp_ppn);
        int errors_before;
        errors_before = errors;
        @(negedge clk);
        check_xlat(name, exp_mode, exp_sum, exp_mxr, exp_asid, exp_ppn);
        report_test(name, errors_before);
    endtask

    initial begin
        rst       = 1'b1;
        csr_en    = 1'b0;
        csr_op    = '0;
        csr_addr  = '0;
        csr_src   = '0;
        csr_imm   = '0;
        trap_en   = 1'b0;
        trap_code = EXC_NONE;
        trap_pc   = '0;
        seed      = 32'h61aa_5c2e;
        rand_val  = $random(seed);
        row_mode  = PRIV_M;  // Mode out of reset.
        build_table(rand_val);
        cycle_limit = tests.size() * 3 + 20;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        xlat_test("xlat_reset", PRIV_M, 1'b0, 1'b0, '0, '0);
        foreach (tests[i])
            apply_test(tests[i]);
        @(posedge clk);  // Context registers follow the last write.
        // Trap from S left mpp = S, mprv now set, sum and mxr from the sstatus write.
        xlat_test("xlat_final", PRIV_S, 1'b1, 1'b1, SATP_ASID, SATP_PPN);
        $display("Summary: %0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verification
design/csr_pkg.sv
design/csr_access.sv
design/csr_regfile.sv
design/trap_ctrl.sv
design/csr_unit.sv
verification/csr_unit_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module csr_unit_tb -o csr_unit_sim || exit 1
out=$(./obj_dir/csr_unit_sim)
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1
